//--- verilog/hqm_proc_consts.svh
// Sizing for the status block; unit order is fixed and DONE_DELAY must be at least 2
`ifndef HQM_PROC_CONSTS_SVH
`define HQM_PROC_CONSTS_SVH

// ------------------------------
// Unit count
// ------------------------------
// One status bit per reporting unit
// Index map, low to high
//   0 CHP, 1 ROP, 2 LSP, 3 NALB, 4 AP
//   5 DP, 6 QED, 7 DQED, 8 AQED, 9 SYS
`define HQM_PROC_NUM_UNITS 10

// ------------------------------
// Reset done timing
// ------------------------------
// Register stages from all-units-done to the reset-done output
// Output lands this many cycles after the last sticky bit sets
`define HQM_PROC_DONE_DELAY 4

`endif

//--- verilog/hqm_proc_pkg.sv
// Status types for the processing-partition master; bit order follows the unit index map
package hqm_proc_pkg;

  `include "hqm_proc_consts.svh"

  // ------------------------------
  // Per-unit vector
  // ------------------------------
  // Bit n belongs to unit n, CHP at bit 0 and SYS at the top
  typedef logic [`HQM_PROC_NUM_UNITS-1:0] unit_vec_t;

  // ------------------------------
  // Raw status from the units
  // ------------------------------
  // Four level vectors, sampled on the inp gated clock
  // reset_done and lcb_enable are completion-style, low while in FLR
  // unit_idle and unit_pipeidle are idle-style, high while in FLR
  typedef struct packed {
    unit_vec_t reset_done;
    unit_vec_t unit_idle;
    unit_vec_t lcb_enable;
    unit_vec_t unit_pipeidle;
  } unit_status_t;

  // ------------------------------
  // Status words reported upward
  // ------------------------------
  // Idle word, pipe-idle in the upper half
  typedef struct packed {
    unit_vec_t pipeidle;
    unit_vec_t idle;
  } idle_status_t;

  // Reset word
  // Active flag sits above the sticky done bits
  typedef struct packed {
    logic      pf_reset_active;
    unit_vec_t done;
  } reset_status_t;

  // LCB word, one enable per unit
  typedef struct packed {
    unit_vec_t enable;
  } lcb_status_t;

endpackage

//--- verilog/hqm_proc_status_prot.sv
// Purely combinational input clamp; i_hqm_flr_prep must already be on the inp gated clock
`timescale 1ns/1ps

module hqm_proc_status_prot (
    input  logic                        i_hqm_flr_prep
  , input  hqm_proc_pkg::unit_status_t  i_unit_status
  , output hqm_proc_pkg::unit_status_t  o_prot_status
);

  import hqm_proc_pkg::*;

  // ------------------------------
  // FLR mask
  // ------------------------------
  // Prep level fanned out to one bit per unit
  unit_vec_t flr_mask;

  assign flr_mask = {$bits(unit_vec_t){i_hqm_flr_prep}};

  // ------------------------------
  // Idle-style fields
  // ------------------------------
  // Forced high so a unit in FLR never looks busy
  assign o_prot_status.unit_idle     = i_unit_status.unit_idle | flr_mask;
  assign o_prot_status.unit_pipeidle = i_unit_status.unit_pipeidle | flr_mask;

  // ------------------------------
  // Completion-style fields
  // ------------------------------
  // Forced low so a unit in FLR never claims reset done
  // A done level held through prep shows up as a fresh edge once prep drops
  assign o_prot_status.reset_done    = i_unit_status.reset_done & ~flr_mask;

  // LCB enable reads off while the unit is being reset
  assign o_prot_status.lcb_enable    = i_unit_status.lcb_enable & ~flr_mask;

endmodule

//--- verilog/hqm_proc_reset_agg.sv
// Reset-done collector; sticky bits clear only on reset and inputs must be protected levels
`timescale 1ns/1ps

`include "hqm_proc_consts.svh"

module hqm_proc_reset_agg (
    input  logic                         hqm_inp_gated_clk
  , input  logic                         hqm_cdc_hqm_gated_rst_b_sync
  , input  hqm_proc_pkg::unit_vec_t      i_reset_done
  , output hqm_proc_pkg::unit_vec_t      o_done_sticky
  , output hqm_proc_pkg::reset_status_t  o_reset_status
  , output logic                         o_reset_done
);

  import hqm_proc_pkg::*;

  // Previous done levels, zero out of reset
  unit_vec_t done_prev_f;
  // Rising edges this cycle
  unit_vec_t done_rise;
  // Held done bits
  unit_vec_t done_sticky_f;
  unit_vec_t done_sticky_nxt;

  logic      all_done;
  logic      pf_rst_active_f;

  // Done delay chain, stage 0 first
  logic [`HQM_PROC_DONE_DELAY-1:0] done_pipe_f;

  // ------------------------------
  // Edge detect and sticky hold
  // ------------------------------
  // Level high now but low last cycle
  // A level already high at reset release counts as an edge
  assign done_rise       = i_reset_done & ~done_prev_f;
  assign done_sticky_nxt = done_sticky_f | done_rise;

  // Every unit has reported
  assign all_done        = &done_sticky_f;

  always_ff @(posedge hqm_inp_gated_clk or negedge hqm_cdc_hqm_gated_rst_b_sync) begin
    if (!hqm_cdc_hqm_gated_rst_b_sync) begin
      done_prev_f     <= '0;
      done_sticky_f   <= '0;
    end else begin
      done_prev_f     <= i_reset_done;
      done_sticky_f   <= done_sticky_nxt;
    end
  end

  // ------------------------------
  // PF reset active
  // ------------------------------
  // Set out of reset, drops one cycle after the last sticky bit
  always_ff @(posedge hqm_inp_gated_clk or negedge hqm_cdc_hqm_gated_rst_b_sync) begin
    if (!hqm_cdc_hqm_gated_rst_b_sync) begin
      pf_rst_active_f <= 1'b1;
    end else begin
      pf_rst_active_f <= ~all_done;
    end
  end

  // ------------------------------
  // Reset done delay
  // ------------------------------
  // All-done shifts up the chain, last stage is the output
  always_ff @(posedge hqm_inp_gated_clk or negedge hqm_cdc_hqm_gated_rst_b_sync) begin
    if (!hqm_cdc_hqm_gated_rst_b_sync) begin
      done_pipe_f <= '0;
    end else begin
      done_pipe_f <= {done_pipe_f[`HQM_PROC_DONE_DELAY-2:0], all_done};
    end
  end

  assign o_reset_done                   = done_pipe_f[`HQM_PROC_DONE_DELAY-1];

  // Status word and sticky view for the idle side
  assign o_reset_status.pf_reset_active = pf_rst_active_f;
  assign o_reset_status.done            = done_sticky_f;
  assign o_done_sticky                  = done_sticky_f;

endmodule

//--- verilog/hqm_proc_idle_agg.sv
// Idle and LCB status registers; all words lag their protected inputs by one cycle
`timescale 1ns/1ps

module hqm_proc_idle_agg (
    input  logic                        hqm_inp_gated_clk
  , input  logic                        hqm_cdc_hqm_gated_rst_b_sync
  , input  hqm_proc_pkg::unit_vec_t     i_unit_idle
  , input  hqm_proc_pkg::unit_vec_t     i_unit_pipeidle
  , input  hqm_proc_pkg::unit_vec_t     i_lcb_enable
  , input  hqm_proc_pkg::unit_vec_t     i_done_sticky
  , output hqm_proc_pkg::idle_status_t  o_idle_status
  , output hqm_proc_pkg::lcb_status_t   o_lcb_status
  , output logic                        o_pipeidle
  , output logic                        o_unit_idle
);

  import hqm_proc_pkg::*;

  idle_status_t idle_status_f;
  idle_status_t idle_status_nxt;
  lcb_status_t  lcb_status_f;
  lcb_status_t  lcb_status_nxt;

  logic         unit_idle_f;
  logic         unit_idle_nxt;

  // ------------------------------
  // Next status words
  // ------------------------------
  assign idle_status_nxt.pipeidle = i_unit_pipeidle;
  assign idle_status_nxt.idle     = i_unit_idle;
  assign lcb_status_nxt.enable    = i_lcb_enable;

  // Partition idle only once every unit is idle
  // and every unit has finished its reset
  assign unit_idle_nxt = (&i_unit_idle) & (&i_done_sticky);

  // ------------------------------
  // Status registers
  // ------------------------------
  // Idle reads all ones out of reset, LCB reads off
  always_ff @(posedge hqm_inp_gated_clk or negedge hqm_cdc_hqm_gated_rst_b_sync) begin
    if (!hqm_cdc_hqm_gated_rst_b_sync) begin
      idle_status_f <= '1;
      lcb_status_f  <= '0;
      unit_idle_f   <= 1'b0;
    end else begin
      idle_status_f <= idle_status_nxt;
      lcb_status_f  <= lcb_status_nxt;
      unit_idle_f   <= unit_idle_nxt;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign o_idle_status = idle_status_f;
  assign o_lcb_status  = lcb_status_f;

  // Observation bit, AND of the held pipe-idle vector
  assign o_pipeidle    = &idle_status_f.pipeidle;

  assign o_unit_idle   = unit_idle_f;

endmodule

//--- verilog/hqm_proc_master.sv
// Status side of the partition master; one clock, reset taken as already synchronized
`timescale 1ns/1ps

module hqm_proc_master (
    input  logic                         hqm_inp_gated_clk
  , input  logic                         hqm_cdc_hqm_gated_rst_b_sync

  // Raw unit status
  , input  logic                         i_hqm_flr_prep
  , input  hqm_proc_pkg::unit_status_t   i_unit_status

  // Aggregate levels
  , output logic                         o_reset_done
  , output logic                         o_unit_idle

  // Status words
  , output hqm_proc_pkg::reset_status_t  o_reset_status
  , output hqm_proc_pkg::idle_status_t   o_idle_status
  , output hqm_proc_pkg::lcb_status_t    o_lcb_status

  // Observation
  , output logic                         o_pipeidle
);

  import hqm_proc_pkg::*;

  // Status after the FLR clamp
  unit_status_t prot_status;
  // Held done bits feeding the idle aggregate
  unit_vec_t    done_sticky;

  // ------------------------------
  // Interface protection
  // ------------------------------
  hqm_proc_status_prot i_status_prot (
      .i_hqm_flr_prep  (i_hqm_flr_prep)
    , .i_unit_status   (i_unit_status)
    , .o_prot_status   (prot_status)
  );

  // ------------------------------
  // Reset done aggregation
  // ------------------------------
  hqm_proc_reset_agg i_reset_agg (
      .hqm_inp_gated_clk             (hqm_inp_gated_clk)
    , .hqm_cdc_hqm_gated_rst_b_sync  (hqm_cdc_hqm_gated_rst_b_sync)
    , .i_reset_done                  (prot_status.reset_done)
    , .o_done_sticky                 (done_sticky)
    , .o_reset_status                (o_reset_status)
    , .o_reset_done                  (o_reset_done)
  );

  // ------------------------------
  // Idle aggregation
  // ------------------------------
  // Needs the sticky done bits so idle waits for reset
  hqm_proc_idle_agg i_idle_agg (
      .hqm_inp_gated_clk             (hqm_inp_gated_clk)
    , .hqm_cdc_hqm_gated_rst_b_sync  (hqm_cdc_hqm_gated_rst_b_sync)
    , .i_unit_idle                   (prot_status.unit_idle)
    , .i_unit_pipeidle               (prot_status.unit_pipeidle)
    , .i_lcb_enable                  (prot_status.lcb_enable)
    , .i_done_sticky                 (done_sticky)
    , .o_idle_status                 (o_idle_status)
    , .o_lcb_status                  (o_lcb_status)
    , .o_pipeidle                    (o_pipeidle)
    , .o_unit_idle                   (o_unit_idle)
  );

endmodule

//--- testbench/tb_hqm_proc_tests.svh
// Directed tests for the status block; included inside the testbench module, relies on its helpers
`ifndef TB_HQM_PROC_TESTS_SVH
`define TB_HQM_PROC_TESTS_SVH

// ------------------------------
// Reset values
// ------------------------------
// Sampled right after release, before any clock edge moves the registers
task automatic test_reset_values();
  reset_status_t exp_rs;
  idle_status_t  exp_idle;
  lcb_status_t   exp_lcb;
  begin_test();
  exp_rs.pf_reset_active = 1'b1;
  exp_rs.done            = '0;
  exp_idle               = '1;
  exp_lcb                = '0;
  compare_logic("o_reset_done", reset_done, 1'b0);
  compare_logic("o_unit_idle", unit_idle, 1'b0);
  compare_reset_status("o_reset_status", reset_status, exp_rs);
  compare_idle_status("o_idle_status", idle_status, exp_idle);
  compare_lcb_status("o_lcb_status", lcb_status, exp_lcb);
  compare_logic("o_pipeidle", pipeidle, 1'b1);
  // Inputs still low, nothing should set
  step(1);
  compare_reset_status("o_reset_status", reset_status, exp_rs);
  end_test("reset_values");
endtask

// ------------------------------
// Sticky reset done
// ------------------------------
task automatic test_sticky_done();
  int            pool[$];
  int            order[$];
  int            j;
  int            k;
  int            cnt;
  unit_vec_t     done_in;
  unit_vec_t     raised;
  unit_vec_t     prev_raised;
  reset_status_t exp_rs;
  begin_test();
  done_in = '0;
  raised  = '0;
  for (k = 0; k < `HQM_PROC_NUM_UNITS; k++) pool.push_back(k);
  // Random raise order
  while (pool.size() > 0) begin
    j = $urandom_range(pool.size() - 1, 0);
    order.push_back(pool[j]);
    pool.delete(j);
  end
  for (k = 0; k < `HQM_PROC_NUM_UNITS; k++) begin
    prev_raised = raised;
    done_in     = done_in | unit_bit(order[k]);
    raised      = raised | unit_bit(order[k]);
    drive_status(done_in, '0, '0, '0);
    step(1);
    // Flag tracks the sticky vector one edge late
    exp_rs.done            = raised;
    exp_rs.pf_reset_active = ~&prev_raised;
    compare_reset_status("o_reset_status", reset_status, exp_rs);
    if (k < `HQM_PROC_NUM_UNITS - 1) begin
      compare_logic("o_reset_done", reset_done, 1'b0);
      // Now and then drop an input that already reported
      if ($urandom_range(2, 0) == 0) begin
        j       = $urandom_range(k, 0);
        done_in = done_in & ~unit_bit(order[j]);
        drive_status(done_in, '0, '0, '0);
        step(1);
        exp_rs.pf_reset_active = 1'b1;
        compare_reset_status("o_reset_status", reset_status, exp_rs);
      end
    end
  end
  // One cycle already spent since the last input was sampled
  cnt = 1;
  while (!reset_done && cnt < WAIT_LIMIT) begin
    step(1);
    cnt++;
    if (cnt == 2) compare_logic("pf_reset_active", reset_status.pf_reset_active, 1'b0);
  end
  if (!reset_done) begin
    error_count++;
    $display("Timeout at %0t: o_reset_done never rose after all units were done", $time);
  end else if (cnt != `HQM_PROC_DONE_DELAY + 1) begin
    error_count++;
    $display("o_reset_done rose %0d cycles after the last done input, not %0d", cnt,
             `HQM_PROC_DONE_DELAY + 1);
  end
  // Dropping inputs after completion changes nothing
  done_in = rand_vec();
  drive_status(done_in, '0, '0, '0);
  step(2);
  compare_unit_vec("o_reset_status.done", reset_status.done, '1);
  compare_logic("o_reset_done", reset_done, 1'b1);
  end_test("sticky_done");
endtask

// ------------------------------
// Status mirroring
// ------------------------------
task automatic test_status_mirror();
  int           k;
  unit_vec_t    idle;
  unit_vec_t    pipe;
  unit_vec_t    lcb;
  idle_status_t exp_idle;
  lcb_status_t  exp_lcb;
  begin_test();
  for (k = 0; k < 8; k++) begin
    idle = rand_vec();
    // First pass covers the all-idle observation bit
    pipe = (k == 0) ? '1 : rand_vec();
    lcb  = rand_vec();
    drive_status('1, idle, pipe, lcb);
    step(1);
    exp_idle.pipeidle = pipe;
    exp_idle.idle     = idle;
    exp_lcb.enable    = lcb;
    compare_idle_status("o_idle_status", idle_status, exp_idle);
    compare_lcb_status("o_lcb_status", lcb_status, exp_lcb);
    compare_logic("o_pipeidle", pipeidle, &pipe);
  end
  end_test("status_mirror");
endtask

// ------------------------------
// Aggregate idle
// ------------------------------
task automatic test_aggregate_idle();
  int        last;
  int        b;
  int        k;
  int        cnt;
  unit_vec_t done_in;
  unit_vec_t idle;
  begin_test();
  apply_reset();
  last    = $urandom_range(`HQM_PROC_NUM_UNITS - 1, 0);
  done_in = ~unit_bit(last);
  idle    = '1;
  drive_status(done_in, idle, '1, '0);
  // All idle, one unit still in reset
  for (k = 0; k < 4; k++) begin
    step(1);
    compare_logic("o_unit_idle", unit_idle, 1'b0);
  end
  done_in = '1;
  drive_status(done_in, idle, '1, '0);
  cnt = 0;
  while (!unit_idle && cnt < WAIT_LIMIT) begin
    step(1);
    cnt++;
  end
  if (!unit_idle) begin
    error_count++;
    $display("Timeout at %0t: o_unit_idle never rose once all units were done", $time);
  end else if (cnt > 2) begin
    error_count++;
    $display("o_unit_idle took %0d cycles to rise, more than 2", cnt);
  end
  // One busy unit drops the aggregate
  b    = $urandom_range(`HQM_PROC_NUM_UNITS - 1, 0);
  idle = ~unit_bit(b);
  drive_status(done_in, idle, '1, '0);
  step(1);
  compare_logic("o_unit_idle", unit_idle, 1'b0);
  idle = '1;
  drive_status(done_in, idle, '1, '0);
  step(1);
  compare_logic("o_unit_idle", unit_idle, 1'b1);
  end_test("aggregate_idle");
endtask

// ------------------------------
// FLR protection
// ------------------------------
task automatic test_flr_protection();
  int            unit;
  int            k;
  unit_vec_t     done_in;
  idle_status_t  exp_idle;
  lcb_status_t   exp_lcb;
  begin_test();
  apply_reset();
  unit    = $urandom_range(`HQM_PROC_NUM_UNITS - 1, 0);
  done_in = rand_vec() | unit_bit(unit);
  // Keep one unit short so the active flag stays up
  if (&done_in) done_in = done_in & ~unit_bit((unit + 1) % `HQM_PROC_NUM_UNITS);
  exp_idle = '1;
  exp_lcb  = '0;
  flr_prep = 1'b1;
  for (k = 0; k < 6; k++) begin
    drive_status(done_in, rand_vec(), rand_vec(), rand_vec());
    step(1);
    compare_idle_status("o_idle_status", idle_status, exp_idle);
    compare_lcb_status("o_lcb_status", lcb_status, exp_lcb);
    compare_logic("o_pipeidle", pipeidle, 1'b1);
    compare_unit_vec("o_reset_status.done", reset_status.done, '0);
  end
  // Held done levels become edges once prep drops
  flr_prep = 1'b0;
  step(1);
  compare_unit_vec("o_reset_status.done", reset_status.done, done_in);
  compare_logic("pf_reset_active", reset_status.pf_reset_active, 1'b1);
  end_test("flr_protection");
endtask

`endif

//--- testbench/tb_hqm_proc_master.sv
// Directed testbench for the status block; needs timing support, single fixed seed, no file output
`timescale 1ns/1ps

`include "hqm_proc_consts.svh"

module tb_hqm_proc_master;

  import hqm_proc_pkg::*;

  // Longest bounded wait, in clock cycles
  localparam int WAIT_LIMIT = 20;

  logic          hqm_inp_gated_clk;
  logic          hqm_cdc_hqm_gated_rst_b_sync;

  // DUT inputs
  logic          flr_prep;
  unit_status_t  unit_status;

  // DUT outputs
  logic          reset_done;
  logic          unit_idle;
  reset_status_t reset_status;
  idle_status_t  idle_status;
  lcb_status_t   lcb_status;
  logic          pipeidle;

  // Bookkeeping
  int            error_count;
  int            test_err_start;
  int            tests_run;
  int            tests_failed;

  // ------------------------------
  // Clock and DUT
  // ------------------------------
  // 4 ns period
  always #2 hqm_inp_gated_clk = ~hqm_inp_gated_clk;

  hqm_proc_master i_dut (
      .hqm_inp_gated_clk             (hqm_inp_gated_clk)
    , .hqm_cdc_hqm_gated_rst_b_sync  (hqm_cdc_hqm_gated_rst_b_sync)
    , .i_hqm_flr_prep                (flr_prep)
    , .i_unit_status                 (unit_status)
    , .o_reset_done                  (reset_done)
    , .o_unit_idle                   (unit_idle)
    , .o_reset_status                (reset_status)
    , .o_idle_status                 (idle_status)
    , .o_lcb_status                  (lcb_status)
    , .o_pipeidle                    (pipeidle)
  );

  // ------------------------------
  // Timing helpers
  // ------------------------------
  // Inputs change and outputs are sampled on the falling edge
  task automatic step(input int n);
    repeat (n) @(negedge hqm_inp_gated_clk);
  endtask

  // Reset held low for 5 cycles, inputs back to idle levels
  task automatic apply_reset();
    flr_prep                     = 1'b0;
    unit_status                  = '0;
    hqm_cdc_hqm_gated_rst_b_sync = 1'b0;
    step(5);
    hqm_cdc_hqm_gated_rst_b_sync = 1'b1;
  endtask

  task automatic drive_status(input unit_vec_t done, input unit_vec_t idle,
                              input unit_vec_t pipe, input unit_vec_t lcb);
    unit_status.reset_done    = done;
    unit_status.unit_idle     = idle;
    unit_status.unit_pipeidle = pipe;
    unit_status.lcb_enable    = lcb;
  endtask

  // One-hot vector for a unit index
  function automatic unit_vec_t unit_bit(input int idx);
    return unit_vec_t'(1) << idx;
  endfunction

  function automatic unit_vec_t rand_vec();
    logic [31:0] r;
    r = $urandom();
    return r[`HQM_PROC_NUM_UNITS-1:0];
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic compare_logic(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_unit_vec(input string name, input unit_vec_t got, input unit_vec_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_idle_status(input string name, input idle_status_t got,
                                     input idle_status_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_reset_status(input string name, input reset_status_t got,
                                      input reset_status_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_lcb_status(input string name, input lcb_status_t got,
                                    input lcb_status_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Per-test result line
  task automatic begin_test();
    test_err_start = error_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count == test_err_start) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - test_err_start);
    end
  endtask

  `include "tb_hqm_proc_tests.svh"

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    hqm_inp_gated_clk = 1'b0;
    error_count       = 0;
    test_err_start    = 0;
    tests_run         = 0;
    tests_failed      = 0;
    void'($urandom(32'hb023));
    apply_reset();

    // Sticky bits only clear on reset, so order matters here
    test_reset_values();
    test_sticky_done();
    test_status_mirror();
    test_aggregate_idle();
    test_flr_protection();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+verilog
+incdir+testbench
verilog/hqm_proc_pkg.sv
verilog/hqm_proc_status_prot.sv
verilog/hqm_proc_reset_agg.sv
verilog/hqm_proc_idle_agg.sv
verilog/hqm_proc_master.sv
testbench/tb_hqm_proc_master.sv

//--- run.sh
#!/bin/sh
# Build and run the status block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_hqm_proc_master

verilator --binary --timing -f list.f --top-module "$TOP" -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
